// ==== hw/channel_sum_store.sv ====
`timescale 1ns/1ps

module channel_sum_store import fmap_pkg::*; (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_load_en,
	input  logic             i_in_valid,
	input  logic [PIX_W-1:0] i_in_data,
	output logic             o_load_done,
	map_rd_if.slave          rd
);

	logic [$clog2(LOAD_BYTES)-1:0] byte_cnt;
	logic [$clog2(NUM_CH)-1:0]     chan;
	logic [PIX_AW-1:0]             pix;
	logic                          accept;
	logic [SUM_W-1:0]              new_sum;

	// running sums over channels 0-7, 0-15 and 0-31
	logic [SUM_W-1:0] bank_8  [2**PIX_AW];
	logic [SUM_W-1:0] bank_16 [2**PIX_AW];
	logic [SUM_W-1:0] bank_32 [2**PIX_AW];

	// ----------------------------------------
	// load side
	// ----------------------------------------
	assign {chan, pix} = byte_cnt;  // channel-major, row-major inside
	assign accept      = i_load_en && i_in_valid;
	assign o_load_done = accept && (byte_cnt == LOAD_BYTES - 1);

	// first channel starts the sum fresh
	assign new_sum = (chan == '0) ? SUM_W'(i_in_data) : bank_32[pix] + SUM_W'(i_in_data);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			byte_cnt <= '0;
		else if (accept)
			byte_cnt <= byte_cnt + 1'b1;  // wraps to 0 after the last byte
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			bank_32[pix] <= new_sum;
			if (chan < NUM_CH / 2)
				bank_16[pix] <= new_sum;
			if (chan < NUM_CH / 4)
				bank_8[pix] <= new_sum;
		end
	end

	// ----------------------------------------
	// read side
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (rd.rd_en) begin
			case (rd.rd_bank)
				DEPTH_8:  rd.rd_data <= bank_8[rd.rd_addr];
				DEPTH_16: rd.rd_data <= bank_16[rd.rd_addr];
				default:  rd.rd_data <= bank_32[rd.rd_addr];
			endcase
		end
	end

	// load must never end before the full 2048 bytes are in
	a_cnt_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_load_en |-> byte_cnt == '0);

endmodule

// ==== hw/conv_engine.sv ====
`timescale 1ns/1ps

module conv_engine import fmap_pkg::*; (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_conv_start,
	input  logic [2:0]       i_org_row,
	input  logic [2:0]       i_org_col,
	input  depth_e           i_depth,
	map_rd_if.master         rd,
	output logic             o_out_valid,
	output logic [SUM_W-1:0] o_out_data,
	output logic             o_conv_done
);

	typedef enum logic [1:0] {C_IDLE, C_GATHER, C_DRAIN, C_OUT} conv_state_e;

	conv_state_e      state;
	logic [3:0]       step;      // 4x4 neighbourhood, row-major
	logic [3:0]       step_d;    // step whose data is on rd_data
	logic             data_vld;
	logic             data_hit;  // a read was issued, else zero pad
	logic [1:0]       out_idx;
	logic [3:0]       cell_row;
	logic [3:0]       cell_col;
	logic [SUM_W-1:0] px_val;
	logic [2:0]       wgt [4];
	logic [ACC_W-1:0] acc [4];   // tl, tr, bl, br
	logic [ACC_W-1:0] acc_sel;

	// 1 2 1 tap along one axis, ctr is the window pixel inside the 4x4
	function automatic logic [1:0] tap(input logic [1:0] pos, input logic [1:0] ctr);
		if (pos == ctr)
			return 2'd2;
		else if (pos + 2'd1 == ctr || pos == ctr + 2'd1)
			return 2'd1;
		else
			return 2'd0;
	endfunction

	// ----------------------------------------
	// gather reads
	// ----------------------------------------
	// one up and one left of the origin, -1 wraps to 15
	assign cell_row = {1'b0, i_org_row} + {2'b00, step[3:2]} - 4'd1;
	assign cell_col = {1'b0, i_org_col} + {2'b00, step[1:0]} - 4'd1;

	assign rd.rd_en   = (state == C_GATHER) && !cell_row[3] && !cell_col[3];
	assign rd.rd_addr = {cell_row[2:0], cell_col[2:0]};
	assign rd.rd_bank = i_depth;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= C_IDLE;
			step     <= 4'd0;
			step_d   <= 4'd0;
			data_vld <= 1'b0;
			data_hit <= 1'b0;
			out_idx  <= 2'd0;
		end else begin
			step_d   <= step;
			data_vld <= (state == C_GATHER);
			data_hit <= rd.rd_en;
			case (state)
				C_IDLE: begin
					if (i_conv_start) begin
						state <= C_GATHER;
						step  <= 4'd0;
					end
				end
				C_GATHER: begin
					step <= step + 4'd1;
					if (step == 4'd15)
						state <= C_DRAIN;  // last read still in flight
				end
				C_DRAIN: begin
					state   <= C_OUT;
					out_idx <= 2'd0;
				end
				C_OUT: begin
					out_idx <= out_idx + 2'd1;
					if (out_idx == 2'd3)
						state <= C_IDLE;
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// weighted accumulation
	// ----------------------------------------
	assign px_val = data_hit ? rd.rd_data : '0;

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			wgt[k] = {1'b0, tap(step_d[3:2], 2'(k >> 1) + 2'd1)}
				* {1'b0, tap(step_d[1:0], 2'(k & 1) + 2'd1)};  // 4, 2, 1 or 0
		end
	end

	always_ff @(posedge i_clk) begin
		for (int k = 0; k < 4; k++) begin
			if (state == C_IDLE && i_conv_start)
				acc[k] <= '0;
			else if (data_vld)
				acc[k] <= acc[k] + ACC_W'(px_val) * ACC_W'(wgt[k]);
		end
	end

	// divide by 16, round half up
	assign acc_sel     = acc[out_idx];
	assign o_out_data  = acc_sel[ACC_W-1:4] + SUM_W'(acc_sel[3]);
	assign o_out_valid = (state == C_OUT);
	assign o_conv_done = o_out_valid && (out_idx == 2'd3);

	a_one_in_flight: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_conv_start |-> state == C_IDLE);
	a_out_burst: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid [*4] |=> !o_out_valid);

endmodule

// ==== hw/fmap_core.sv ====
`timescale 1ns/1ps

module fmap_core import fmap_pkg::*; (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_op_valid,
	input  logic [3:0]       i_op_mode,
	output logic             o_op_ready,
	input  logic             i_in_valid,
	input  logic [PIX_W-1:0] i_in_data,
	output logic             o_in_ready,
	output logic             o_out_valid,
	output logic [SUM_W-1:0] o_out_data
);

	win_cmd_e   win_cmd;
	logic       load_en;
	logic       load_done;
	logic       conv_start;
	logic       conv_done;
	logic [2:0] org_row;
	logic [2:0] org_col;
	depth_e     depth;

	map_rd_if map_rd ();

	op_sequencer u_op_sequencer (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_op_valid   (i_op_valid),
		.i_op_mode    (op_mode_e'(i_op_mode)),
		.o_op_ready   (o_op_ready),
		.o_in_ready   (o_in_ready),
		.o_load_en    (load_en),
		.i_load_done  (load_done),
		.o_win_cmd    (win_cmd),
		.o_conv_start (conv_start),
		.i_conv_done  (conv_done)
	);

	channel_sum_store u_channel_sum_store (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_load_en   (load_en),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_load_done (load_done),
		.rd          (map_rd.slave)
	);

	window_state u_window_state (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_win_cmd (win_cmd),
		.o_org_row (org_row),
		.o_org_col (org_col),
		.o_depth   (depth)
	);

	conv_engine u_conv_engine (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_conv_start (conv_start),
		.i_org_row    (org_row),
		.i_org_col    (org_col),
		.i_depth      (depth),
		.rd           (map_rd.master),
		.o_out_valid  (o_out_valid),
		.o_out_data   (o_out_data),
		.o_conv_done  (conv_done)
	);

endmodule

// ==== hw/fmap_pkg.sv ====
package fmap_pkg;

	// ----------------------------------------
	// map geometry
	// ----------------------------------------
	localparam int MAP_DIM    = 8;     // pixels per side
	localparam int PIX_AW     = 6;     // row/col packed as {row, col}
	localparam int NUM_CH     = 32;
	localparam int LOAD_BYTES = 2048;  // NUM_CH * MAP_DIM * MAP_DIM
	localparam int PIX_W      = 8;

	// ----------------------------------------
	// datapath widths
	// ----------------------------------------
	localparam int SUM_W   = 13;  // 32 * 255 fits
	localparam int ACC_W   = 17;  // 16 weighted taps of a 13-bit sum
	localparam int ORG_MAX = MAP_DIM - 2;

	// op codes seen on i_op_mode, 8 and up are ignored
	typedef enum logic [3:0] {
		OP_LOAD_MAP    = 4'd0,
		OP_SHIFT_RIGHT = 4'd1,
		OP_SHIFT_LEFT  = 4'd2,
		OP_SHIFT_UP    = 4'd3,
		OP_SHIFT_DOWN  = 4'd4,
		OP_SCALE_DOWN  = 4'd5,
		OP_SCALE_UP    = 4'd6,
		OP_CONV_SHOW   = 4'd7
	} op_mode_e;

	typedef enum logic [2:0] {
		WIN_NONE,
		WIN_RIGHT,
		WIN_LEFT,
		WIN_UP,
		WIN_DOWN,
		WIN_HALF,
		WIN_DOUBLE,
		WIN_DEPTH_MAX
	} win_cmd_e;

	typedef enum logic [1:0] {DEPTH_8, DEPTH_16, DEPTH_32} depth_e;

endpackage

// ==== hw/map_rd_if.sv ====
`timescale 1ns/1ps

// read port into the channel-sum banks, data one cycle after rd_en
interface map_rd_if import fmap_pkg::*; ();

	logic              rd_en;
	logic [PIX_AW-1:0] rd_addr;  // {row, col}
	depth_e            rd_bank;
	logic [SUM_W-1:0]  rd_data;

	modport master (
		output rd_en, rd_addr, rd_bank,
		input  rd_data
	);

	modport slave (
		input  rd_en, rd_addr, rd_bank,
		output rd_data
	);

endinterface

// ==== hw/op_sequencer.sv ====
`timescale 1ns/1ps

module op_sequencer import fmap_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_op_valid,
	input  op_mode_e i_op_mode,
	output logic     o_op_ready,
	output logic     o_in_ready,
	output logic     o_load_en,
	input  logic     i_load_done,
	output win_cmd_e o_win_cmd,
	output logic     o_conv_start,
	input  logic     i_conv_done
);

	typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_LOAD, S_CONV} seq_state_e;

	seq_state_e state;
	seq_state_e state_nx;
	logic       op_ready_q;

	// ----------------------------------------
	// next state and command dispatch
	// ----------------------------------------
	always_comb begin
		state_nx     = state;
		o_win_cmd    = WIN_NONE;
		o_conv_start = 1'b0;
		case (state)
			S_IDLE:  state_nx = S_FETCH;
			S_FETCH: state_nx = S_EXEC;
			S_EXEC: begin
				if (i_op_valid) begin
					state_nx = S_FETCH;  // shift, scale and unknown codes
					case (i_op_mode)
						OP_LOAD_MAP: begin
							o_win_cmd = WIN_DEPTH_MAX;  // new map starts at full depth
							state_nx  = S_LOAD;
						end
						OP_SHIFT_RIGHT: o_win_cmd = WIN_RIGHT;
						OP_SHIFT_LEFT:  o_win_cmd = WIN_LEFT;
						OP_SHIFT_UP:    o_win_cmd = WIN_UP;
						OP_SHIFT_DOWN:  o_win_cmd = WIN_DOWN;
						OP_SCALE_DOWN:  o_win_cmd = WIN_HALF;
						OP_SCALE_UP:    o_win_cmd = WIN_DOUBLE;
						OP_CONV_SHOW: begin
							o_conv_start = 1'b1;
							state_nx     = S_CONV;
						end
						default: ;
					endcase
				end
			end
			S_LOAD: if (i_load_done) state_nx = S_FETCH;
			S_CONV: if (i_conv_done) state_nx = S_FETCH;
			default: state_nx = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= S_IDLE;
			op_ready_q <= 1'b0;
		end else begin
			state      <= state_nx;
			op_ready_q <= (state == S_FETCH);  // one pulse per fetch
		end
	end

	assign o_op_ready = op_ready_q;
	assign o_load_en  = (state == S_LOAD);
	assign o_in_ready = o_load_en;

endmodule

// ==== hw/window_state.sv ====
`timescale 1ns/1ps

module window_state import fmap_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  win_cmd_e   i_win_cmd,
	output logic [2:0] o_org_row,
	output logic [2:0] o_org_col,
	output depth_e     o_depth
);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_org_row <= 3'd0;
			o_org_col <= 3'd0;
			o_depth   <= DEPTH_32;
		end else begin
			case (i_win_cmd)
				WIN_RIGHT: begin
					if (o_org_col < ORG_MAX)
						o_org_col <= o_org_col + 3'd1;
				end
				WIN_LEFT: begin
					if (o_org_col != 3'd0)
						o_org_col <= o_org_col - 3'd1;
				end
				WIN_UP: begin
					if (o_org_row != 3'd0)
						o_org_row <= o_org_row - 3'd1;
				end
				WIN_DOWN: begin
					if (o_org_row < ORG_MAX)
						o_org_row <= o_org_row + 3'd1;
				end
				WIN_HALF: begin
					if (o_depth == DEPTH_32)
						o_depth <= DEPTH_16;
					else if (o_depth == DEPTH_16)
						o_depth <= DEPTH_8;  // 8 is the floor
				end
				WIN_DOUBLE: begin
					if (o_depth == DEPTH_8)
						o_depth <= DEPTH_16;
					else if (o_depth == DEPTH_16)
						o_depth <= DEPTH_32;
				end
				WIN_DEPTH_MAX: o_depth <= DEPTH_32;
				default: ;
			endcase
		end
	end

	// 2x2 window stays inside the 8x8 map
	a_row_range: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_org_row <= ORG_MAX);
	a_col_range: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_org_col <= ORG_MAX);

endmodule

// ==== project.f ====
+incdir+tb
hw/fmap_pkg.sv
hw/map_rd_if.sv
hw/op_sequencer.sv
hw/channel_sum_store.sv
hw/window_state.sv
hw/conv_engine.sv
hw/fmap_core.sv
tb/fmap_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fmap_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module fmap_core_tb -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vfmap_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	exit 0
fi
exit 1

// ==== tb/fmap_ref_model.svh ====
`ifndef FMAP_REF_MODEL_SVH
`define FMAP_REF_MODEL_SVH

// sum of one pixel over the first n_ch channels, zero outside the map
function automatic int ref_chan_sum(input logic [7:0] mem [LOAD_BYTES], input int n_ch,
	input int row, input int col);
	int sum;
	sum = 0;
	if (row < 0 || row >= MAP_DIM || col < 0 || col >= MAP_DIM)
		return 0;
	for (int c = 0; c < n_ch; c++)
		sum += mem[c * MAP_DIM * MAP_DIM + row * MAP_DIM + col];
	return sum;
endfunction

// one origin step, a move past an edge keeps the old value
function automatic int ref_step(input int pos, input int delta);
	if (pos + delta < 0 || pos + delta > ORG_MAX)
		return pos;
	return pos + delta;
endfunction

function automatic int ref_depth_half(input int n_ch);
	return (n_ch > 8) ? n_ch / 2 : n_ch;
endfunction

function automatic int ref_depth_double(input int n_ch);
	return (n_ch < NUM_CH) ? n_ch * 2 : n_ch;
endfunction

// k = 0..3 is tl, tr, bl, br of the 2x2 window
function automatic int ref_conv(input logic [7:0] mem [LOAD_BYTES], input int n_ch,
	input int org_row, input int org_col, input int k);
	int row;
	int col;
	int acc;
	int wgt;
	row = org_row + k / 2;
	col = org_col + k % 2;
	acc = 0;
	for (int dr = -1; dr <= 1; dr++) begin
		for (int dc = -1; dc <= 1; dc++) begin
			wgt = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);  // 1 2 1 kernel
			acc += wgt * ref_chan_sum(mem, n_ch, row + dr, col + dc);
		end
	end
	return (acc + 8) / 16;  // divide by 16, half up
endfunction

`endif

// ==== tb/fmap_core_tb.sv ====
`timescale 1ns/1ps

module fmap_core_tb import fmap_pkg::*; ();

	localparam int MAX_CYCLES = 20000;  // two gapped loads plus about 45 ops
	localparam int WAIT_LIMIT = 64;

	logic             i_clk = 1'b0;
	logic             i_rst_n;
	logic             i_op_valid;
	logic [3:0]       i_op_mode;
	logic             o_op_ready;
	logic             i_in_valid;
	logic [PIX_W-1:0] i_in_data;
	logic             o_in_ready;
	logic             o_out_valid;
	logic [SUM_W-1:0] o_out_data;

	int               seed = 32'h0ad3f9c9;
	int               cyc = 0;
	int               err_val = 0;
	int               err_proto = 0;
	int               conv_cnt = 0;
	int               run_len = 0;    // valid beats so far in this burst
	int               bytes_acc = 0;  // bytes taken in the current load
	logic             conv_armed = 1'b0;
	int               exp_res [4];
	logic [PIX_W-1:0] pix_mem [LOAD_BYTES];
	int               m_row = 0;
	int               m_col = 0;
	int               m_depth = NUM_CH;

	`include "fmap_ref_model.svh"

	fmap_core i_fmap_core (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	always #10 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cyc     <= cyc + 1;
		run_len <= o_out_valid ? run_len + 1 : 0;
		if (o_in_ready && i_in_valid)
			bytes_acc <= (bytes_acc == LOAD_BYTES - 1) ? 0 : bytes_acc + 1;
	end

	always @(posedge i_clk) begin
		if (cyc >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, sequence did not finish", cyc);
			$display("errors: %0d mismatches, %0d other", err_val, err_proto);
			$display("Simulation failed");
			$finish;
		end
	end

	// ----------------------------------------
	// protocol and value checks
	// ----------------------------------------
	a_reset_quiet: assert property (@(posedge i_clk)
		(!i_rst_n && cyc > 0) |-> !(o_op_ready || o_in_ready || o_out_valid))
		else begin err_proto++; $display("control output high during reset at %0t", $time); end
	a_ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_op_ready |=> !o_op_ready)
		else begin err_proto++; $display("o_op_ready high longer than one cycle at %0t", $time); end
	a_load_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_in_ready && !(i_in_valid && bytes_acc == LOAD_BYTES - 1)) |=> o_in_ready)
		else begin err_proto++; $display("o_in_ready fell before the last byte at %0t", $time); end
	a_load_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_in_ready && i_in_valid && bytes_acc == LOAD_BYTES - 1) |=> !o_in_ready)
		else begin err_proto++; $display("o_in_ready still high after byte 2048 at %0t", $time); end
	a_out_expected: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid |-> conv_armed)
		else begin err_proto++; $display("o_out_valid without a conv op at %0t", $time); end
	a_burst_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid |-> run_len < 4)
		else begin err_proto++; $display("more than 4 valid beats at %0t", $time); end
	a_burst_len: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(!o_out_valid && run_len != 0) |-> run_len == 4)
		else begin err_proto++; $display("burst of %0d beats, not 4", $sampled(run_len)); end
	a_out_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid |-> int'(o_out_data) == exp_res[run_len % 4])
		else begin
			err_val++;
			$display("MISMATCH at %0t: o_out_data got %0d expected %0d", $time,
				$sampled(o_out_data), exp_res[$sampled(run_len) % 4]);
		end

	// ----------------------------------------
	// stimulus tasks
	// ----------------------------------------
	task automatic wait_op_ready(output int waited);
		waited = 0;
		while (!o_op_ready && waited < WAIT_LIMIT) begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_op_ready) begin
			err_proto++;
			$display("o_op_ready did not pulse within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// called on the falling edge where o_op_ready is high
	task automatic issue_op(input logic [3:0] op);
		i_op_valid = 1'b1;
		i_op_mode  = op;
		@(negedge i_clk);
		i_op_valid = 1'b0;
	endtask

	task automatic simple_op(input logic [3:0] op);
		int waited;
		issue_op(op);
		wait_op_ready(waited);
		if (waited != 1) begin
			err_proto++;
			$display("op %0d: o_op_ready returned after %0d cycles, not 2", op, waited + 1);
		end
		case (op)
			OP_SHIFT_RIGHT: m_col = ref_step(m_col, 1);
			OP_SHIFT_LEFT:  m_col = ref_step(m_col, -1);
			OP_SHIFT_UP:    m_row = ref_step(m_row, -1);
			OP_SHIFT_DOWN:  m_row = ref_step(m_row, 1);
			OP_SCALE_DOWN:  m_depth = ref_depth_half(m_depth);
			OP_SCALE_UP:    m_depth = ref_depth_double(m_depth);
			default: ;
		endcase
	endtask

	task automatic load_map();
		int sent;
		int waited;
		sent = 0;
		for (int i = 0; i < LOAD_BYTES; i++)
			pix_mem[i] = 8'($random(seed));
		issue_op(OP_LOAD_MAP);
		m_depth = NUM_CH;  // a load restores full depth
		while (sent < LOAD_BYTES) begin
			i_in_valid = o_in_ready && (($random(seed) & 3) != 0);  // about one gap in four
			if (i_in_valid) begin
				i_in_data = pix_mem[sent];
				sent++;
			end
			@(negedge i_clk);
		end
		i_in_valid = 1'b0;
		wait_op_ready(waited);
	endtask

	task automatic conv_check();
		int waited;
		for (int k = 0; k < 4; k++)
			exp_res[k] = ref_conv(pix_mem, m_depth, m_row, m_col, k);
		conv_armed = 1'b1;
		issue_op(OP_CONV_SHOW);
		waited = 0;
		while (!o_out_valid && waited < WAIT_LIMIT) begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_out_valid) begin
			err_proto++;
			$display("conv at row %0d col %0d gave no output", m_row, m_col);
		end
		while (o_out_valid)
			@(negedge i_clk);
		conv_armed = 1'b0;
		conv_cnt++;
		wait_op_ready(waited);
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		int waited;
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = 4'd0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		repeat (4) @(negedge i_clk);
		i_rst_n = 1'b1;
		wait_op_ready(waited);

		load_map();
		conv_check();  // origin 0,0, depth 32
		repeat (2) simple_op(OP_SHIFT_LEFT);
		repeat (2) simple_op(OP_SHIFT_UP);
		conv_check();
		repeat (8) simple_op(OP_SHIFT_RIGHT);
		repeat (8) simple_op(OP_SHIFT_DOWN);
		conv_check();  // bottom-right corner
		repeat (3) simple_op(OP_SHIFT_LEFT);
		repeat (3) simple_op(OP_SHIFT_UP);
		conv_check();
		simple_op(OP_SCALE_DOWN);
		conv_check();
		simple_op(OP_SCALE_DOWN);
		conv_check();
		repeat (2) simple_op(OP_SCALE_DOWN);
		conv_check();  // still depth 8
		repeat (3) simple_op(OP_SCALE_UP);
		conv_check();
		for (int op = 8; op < 16; op++)
			simple_op(4'(op));
		repeat (2) simple_op(OP_SCALE_DOWN);
		simple_op(OP_SHIFT_RIGHT);
		load_map();
		conv_check();

		$display("errors: %0d mismatches, %0d other, %0d convs run", err_val, err_proto,
			conv_cnt);
		if (err_val + err_proto == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
